// ==== Bender.yml ====
package:
  name: etx

sources:
  - common/etx_pkg.sv
  - cfg/etx_cfg.sv
  - queue/etx_queue.sv
  - source/etx_arbiter.sv
  - source/etx_remap.sv
  - protocol/etx_protocol.sv
  - source/etx_top.sv
  - target: simulation
    files:
      - verification/etx_tb_checks.sv
      - verification/etx_tb.sv

// ==== cfg/etx_cfg.sv ====
module etx_cfg (
   input  logic               mi_clk,
   input  logic               rst_n,
   input  logic               mi_en,
   input  logic               mi_we,
   input  etx_pkg::mi_addr_t  mi_addr,
   input  etx_pkg::mi_data_t  mi_din,
   input  logic [2:0]         queue_waits,       // {rr, rd, wr}
   input  logic               busy,
   output etx_pkg::mi_data_t  mi_dout,
   output logic               tx_enable,
   output logic               remap_enable,
   output logic               ctrlmode_override,
   output etx_pkg::ctrlmode_t ctrlmode_value,
   output logic [11:0]        remap_mask,
   output logic [11:0]        remap_pattern
);

   logic              wr_en;                     // Bus write strobe
   logic              rd_en;                     // Bus read strobe
   logic [2:0]        waits_q;                   // Sampled queue waits
   logic              busy_q;                    // Sampled framer busy
   etx_pkg::mi_data_t rd_word;                   // Selected register

   assign wr_en = mi_en && mi_we;
   assign rd_en = mi_en && !mi_we;

   // Readback select, unknown addresses give zero
   always_comb
   begin
      rd_word = '0;
      case (mi_addr)
         etx_pkg::REG_TX_CFG:
         begin
            rd_word[etx_pkg::CFG_ENABLE]   = tx_enable;
            rd_word[etx_pkg::CFG_REMAP]    = remap_enable;
            rd_word[etx_pkg::CFG_OVERRIDE] = ctrlmode_override;
            rd_word[etx_pkg::CFG_CTRLMODE_MSB:etx_pkg::CFG_CTRLMODE_LSB] = ctrlmode_value;
         end
         etx_pkg::REG_REMAP_MASK:    rd_word[11:0] = remap_mask;
         etx_pkg::REG_REMAP_PATTERN: rd_word[11:0] = remap_pattern;
         etx_pkg::REG_TX_STATUS:     rd_word[3:0]  = {busy_q, waits_q};
         default:                    rd_word = '0;
      endcase
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         tx_enable         <= 1'b0;              // Transmitter off after reset
         remap_enable      <= 1'b0;
         ctrlmode_override <= 1'b0;
         ctrlmode_value    <= '0;
         remap_mask        <= '0;
         remap_pattern     <= '0;
         waits_q           <= '0;
         busy_q            <= 1'b0;
         mi_dout           <= '0;
      end
      else
      begin
         waits_q <= queue_waits;                 // Status capture every cycle
         busy_q  <= busy;
         if (wr_en && mi_addr == etx_pkg::REG_TX_CFG)
         begin
            tx_enable         <= mi_din[etx_pkg::CFG_ENABLE];
            remap_enable      <= mi_din[etx_pkg::CFG_REMAP];
            ctrlmode_override <= mi_din[etx_pkg::CFG_OVERRIDE];
            ctrlmode_value    <= mi_din[etx_pkg::CFG_CTRLMODE_MSB:etx_pkg::CFG_CTRLMODE_LSB];
         end
         if (wr_en && mi_addr == etx_pkg::REG_REMAP_MASK)
            remap_mask <= mi_din[11:0];
         if (wr_en && mi_addr == etx_pkg::REG_REMAP_PATTERN)
            remap_pattern <= mi_din[11:0];
         if (rd_en)
            mi_dout <= rd_word;                  // Holds until next read
      end
   end

endmodule

// ==== common/etx_pkg.sv ====
package etx_pkg;

   typedef logic [31:0] addr_t;          // Destination address
   typedef logic [31:0] data_t;          // Payload word
   typedef logic [11:0] chip_id_t;       // Compared against addr[31:20]
   typedef logic [3:0]  ctrlmode_t;      // Control-mode field

   // {write, ctrlmode, datamode[1:0], reserved, addr, data}
   localparam int PKT_W = 1 + $bits(ctrlmode_t) + 2 + 1 + $bits(addr_t) + $bits(data_t);

   typedef logic [PKT_W-1:0] packet_t;   // 72-bit link packet

   typedef logic [19:0] mi_addr_t;       // Register bus address
   typedef logic [31:0] mi_data_t;       // Register bus word

   // Field positions inside packet_t
   localparam int PKT_WRITE    = PKT_W - 1;                            // Write flag
   localparam int PKT_ADDR_LSB = $bits(data_t);
   localparam int PKT_ADDR_MSB = PKT_ADDR_LSB + $bits(addr_t) - 1;
   localparam int PKT_ID_LSB   = PKT_ADDR_MSB - $bits(chip_id_t) + 1;  // addr[20]
   localparam int PKT_ID_MSB   = PKT_ADDR_MSB;                         // addr[31]
   localparam int PKT_CTRL_LSB = PKT_ADDR_MSB + 4;                     // Above rsvd, datamode
   localparam int PKT_CTRL_MSB = PKT_CTRL_LSB + $bits(ctrlmode_t) - 1;

   localparam int PACKET_BYTES = PKT_W / 8;                            // Link bytes per packet

   // Register map
   localparam mi_addr_t REG_TX_CFG        = 20'h00000; // En, remap en, override, value
   localparam mi_addr_t REG_REMAP_MASK    = 20'h00004; // Which addr[31:20] bits change
   localparam mi_addr_t REG_REMAP_PATTERN = 20'h00008; // Replacement bits
   localparam mi_addr_t REG_TX_STATUS     = 20'h0000C; // Read only

   // REG_TX_CFG bit positions
   localparam int CFG_ENABLE       = 0;
   localparam int CFG_REMAP        = 1;
   localparam int CFG_OVERRIDE     = 2;
   localparam int CFG_CTRLMODE_LSB = 4;
   localparam int CFG_CTRLMODE_MSB = 7;

endpackage

// ==== filelist.f ====
common/etx_pkg.sv
cfg/etx_cfg.sv
queue/etx_queue.sv
source/etx_arbiter.sv
source/etx_remap.sv
protocol/etx_protocol.sv
source/etx_top.sv
verification/etx_tb_checks.sv
verification/etx_tb.sv

// ==== protocol/etx_protocol.sv ====
module etx_protocol (
   input  logic             mi_clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  etx_pkg::packet_t in_packet,
   input  logic             tx_enable,
   input  logic             txi_wr_wait,
   input  logic             txi_rd_wait,
   output logic             in_ready,
   output logic             busy,
   output logic             txo_frame,
   output logic [7:0]       txo_data
);

   localparam int CNT_W = $clog2(etx_pkg::PACKET_BYTES);

   typedef enum logic [1:0] {
      IDLE,                                    // Waiting for a packet
      SEND,                                    // Frame high, one byte per cycle
      GAP                                      // Frame low between packets
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] byte_cnt;                 // Bytes already on the link
   etx_pkg::packet_t tx_shift;                 // MSB byte drives the lane
   logic             kind_wait;                // Far-end wait for this packet
   logic             start;

   // Writes wait on txi_wr_wait, everything else on txi_rd_wait
   assign kind_wait = in_packet[etx_pkg::PKT_WRITE] ? txi_wr_wait : txi_rd_wait;
   assign in_ready  = (state == IDLE) && tx_enable && !kind_wait;
   assign start     = in_valid && in_ready;
   assign busy      = (state != IDLE);
   assign txo_frame = (state == SEND);
   assign txo_data  = tx_shift[$bits(etx_pkg::packet_t)-1 -: 8];

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         state    <= IDLE;
         byte_cnt <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (start)
               begin
                  state    <= SEND;
                  byte_cnt <= '0;
               end
            SEND:
            begin
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt == CNT_W'(etx_pkg::PACKET_BYTES - 1))
                  state <= GAP;                // Last byte out, wait ignored meanwhile
            end
            GAP:     state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge mi_clk)
   begin
      if (start)
         tx_shift <= in_packet;
      else if (state == SEND)
         tx_shift <= tx_shift << 8;            // Next byte up
   end

   a_frame_len: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $rose(txo_frame) |-> txo_frame [*etx_pkg::PACKET_BYTES] ##1 !txo_frame);
   // Remap keeps its offer steady until taken
   a_in_stable: assert property (@(posedge mi_clk) disable iff (!rst_n)
      in_valid && !in_ready |=> in_valid && $stable(in_packet));

endmodule

// ==== queue/etx_queue.sv ====
module etx_queue #(
   parameter int depth = 8,
   parameter bit drop_self = 1'b0,
   parameter etx_pkg::chip_id_t chip_id = '0
) (
   input  logic             mi_clk,
   input  logic             rst_n,
   input  logic             access,
   input  etx_pkg::packet_t packet_in,
   input  logic             pop,
   output logic             wait_out,
   output logic             empty,
   output etx_pkg::packet_t head
);

   localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
   localparam int CNT_W = $clog2(depth + 1);

   etx_pkg::packet_t  mem [depth];             // Packet storage
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;                   // Packets held
   logic              self_hit;                // Addressed to this chip
   logic              push;

   assign self_hit = drop_self &&
                     (packet_in[etx_pkg::PKT_ID_MSB:etx_pkg::PKT_ID_LSB] == chip_id);
   assign push     = access && !self_hit;      // Dropped packets never enter
   assign empty    = (count == '0);
   assign head     = mem[rd_ptr];
   // Two spare slots cover the cycle the source needs to see wait
   assign wait_out = (count >= CNT_W'(depth - 2));

   always_ff @(posedge mi_clk)
   begin
      if (push)
         mem[wr_ptr] <= packet_in;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(depth - 1)) ? '0 : wr_ptr + 1'b1; // Wrap
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;             // Both or neither
         endcase
      end
   end

   // Source honoring wait never overruns the buffer
   a_no_overflow: assert property (@(posedge mi_clk) disable iff (!rst_n)
      push |-> count < CNT_W'(depth));
   // Arbiter only pops a queue that has a head
   a_no_underflow: assert property (@(posedge mi_clk) disable iff (!rst_n)
      pop |-> !empty);

endmodule

// ==== source/etx_arbiter.sv ====
module etx_arbiter (
   input  logic               mi_clk,
   input  logic               rst_n,
   input  logic               wr_empty,
   input  logic               rd_empty,
   input  logic               rr_empty,
   input  etx_pkg::packet_t   wr_head,
   input  etx_pkg::packet_t   rd_head,
   input  etx_pkg::packet_t   rr_head,
   input  logic               override,
   input  etx_pkg::ctrlmode_t override_value,
   input  logic               ready,
   output logic               wr_pop,
   output logic               rd_pop,
   output logic               rr_pop,
   output logic               valid,
   output etx_pkg::packet_t   packet,
   output logic               response
);

   logic             load;                     // Holding reg free this cycle
   logic             any_pop;
   etx_pkg::packet_t chosen;                   // Selected head after override

   assign load    = !valid || ready;
   // Priority rr, then wr, then rd
   assign rr_pop  = load && !rr_empty;
   assign wr_pop  = load && rr_empty && !wr_empty;
   assign rd_pop  = load && rr_empty && wr_empty && !rd_empty;
   assign any_pop = rr_pop || wr_pop || rd_pop;

   always_comb
   begin
      if (rr_pop)
         chosen = rr_head;                     // Responses pass untouched
      else if (wr_pop)
         chosen = wr_head;
      else
         chosen = rd_head;
      if (override && !rr_pop)
         chosen[etx_pkg::PKT_CTRL_MSB:etx_pkg::PKT_CTRL_LSB] = override_value;
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         valid    <= 1'b0;
         response <= 1'b0;
      end
      else if (any_pop)
      begin
         valid    <= 1'b1;                     // Valid one cycle after pop
         response <= rr_pop;
      end
      else if (ready)
         valid <= 1'b0;                        // Drained with nothing new
   end

   always_ff @(posedge mi_clk)
   begin
      if (any_pop)
         packet <= chosen;
   end

   a_one_pop: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $onehot0({wr_pop, rd_pop, rr_pop}));

endmodule

// ==== source/etx_remap.sv ====
module etx_remap (
   input  logic             mi_clk,
   input  logic             rst_n,
   input  logic             in_valid,
   input  etx_pkg::packet_t in_packet,
   input  logic             response,
   input  logic             remap_enable,
   input  logic [11:0]      mask,
   input  logic [11:0]      pattern,
   input  logic             out_ready,
   output logic             in_ready,
   output logic             out_valid,
   output etx_pkg::packet_t out_packet
);

   etx_pkg::addr_t   in_addr;                  // Destination of incoming packet
   etx_pkg::packet_t remapped;

   assign in_ready = !out_valid || out_ready;  // Single slot stage

   always_comb
   begin
      in_addr  = in_packet[etx_pkg::PKT_ADDR_MSB:etx_pkg::PKT_ADDR_LSB];
      remapped = in_packet;
      if (remap_enable && !response)
         remapped[etx_pkg::PKT_ID_MSB:etx_pkg::PKT_ID_LSB] =
            (in_addr[31:20] & ~mask) | (pattern & mask); // Masked bits take pattern
   end

   always_ff @(posedge mi_clk)
   begin
      if (!rst_n)
         out_valid <= 1'b0;
      else if (in_valid && in_ready)
         out_valid <= 1'b1;
      else if (out_ready)
         out_valid <= 1'b0;
   end

   always_ff @(posedge mi_clk)
   begin
      if (in_valid && in_ready)
         out_packet <= remapped;
   end

endmodule

// ==== source/etx_top.sv ====
module etx_top #(
   parameter etx_pkg::chip_id_t chip_id = '0,
   parameter int queue_depth = 8
) (
   input  logic               mi_clk,
   input  logic               rst_n,
   // Register bus
   input  logic               mi_en,
   input  logic               mi_we,
   input  etx_pkg::mi_addr_t  mi_addr,
   input  etx_pkg::mi_data_t  mi_din,
   output etx_pkg::mi_data_t  mi_dout,
   // Packet sources
   input  logic               wr_access,
   input  etx_pkg::packet_t   wr_packet,
   output logic               wr_wait,
   input  logic               rd_access,
   input  etx_pkg::packet_t   rd_packet,
   output logic               rd_wait,
   input  logic               rr_access,
   input  etx_pkg::packet_t   rr_packet,
   output logic               rr_wait,
   // Link
   output logic               txo_frame,
   output logic [7:0]         txo_data,
   input  logic               txi_wr_wait,
   input  logic               txi_rd_wait
);

   logic              tx_enable;          // Config outputs
   logic              remap_enable;
   logic              ctrlmode_override;
   etx_pkg::ctrlmode_t ctrlmode_value;
   logic [11:0]       remap_mask;
   logic [11:0]       remap_pattern;
   logic              busy;               // Framer mid-packet

   logic              wr_empty;           // Queue heads
   logic              rd_empty;
   logic              rr_empty;
   etx_pkg::packet_t  wr_head;
   etx_pkg::packet_t  rd_head;
   etx_pkg::packet_t  rr_head;
   logic              wr_pop;
   logic              rd_pop;
   logic              rr_pop;

   logic              arb_valid;          // Arbiter -> remap
   logic              arb_ready;
   etx_pkg::packet_t  arb_packet;
   logic              arb_response;

   logic              map_valid;          // Remap -> framer
   logic              map_ready;
   etx_pkg::packet_t  map_packet;

   etx_cfg u_cfg (
      .mi_clk(mi_clk), .rst_n(rst_n), .mi_en(mi_en), .mi_we(mi_we),
      .mi_addr(mi_addr), .mi_din(mi_din), .mi_dout(mi_dout),
      .queue_waits({rr_wait, rd_wait, wr_wait}), .busy(busy),
      .tx_enable(tx_enable), .remap_enable(remap_enable),
      .ctrlmode_override(ctrlmode_override), .ctrlmode_value(ctrlmode_value),
      .remap_mask(remap_mask), .remap_pattern(remap_pattern));

   etx_queue #(.depth(queue_depth), .drop_self(1'b1), .chip_id(chip_id)) u_wr_queue (
      .mi_clk(mi_clk), .rst_n(rst_n), .access(wr_access), .packet_in(wr_packet),
      .pop(wr_pop), .wait_out(wr_wait), .empty(wr_empty), .head(wr_head));

   etx_queue #(.depth(queue_depth), .drop_self(1'b1), .chip_id(chip_id)) u_rd_queue (
      .mi_clk(mi_clk), .rst_n(rst_n), .access(rd_access), .packet_in(rd_packet),
      .pop(rd_pop), .wait_out(rd_wait), .empty(rd_empty), .head(rd_head));

   // Responses always go out, even to our own ID
   etx_queue #(.depth(queue_depth), .drop_self(1'b0), .chip_id(chip_id)) u_rr_queue (
      .mi_clk(mi_clk), .rst_n(rst_n), .access(rr_access), .packet_in(rr_packet),
      .pop(rr_pop), .wait_out(rr_wait), .empty(rr_empty), .head(rr_head));

   etx_arbiter u_arbiter (
      .mi_clk(mi_clk), .rst_n(rst_n),
      .wr_empty(wr_empty), .rd_empty(rd_empty), .rr_empty(rr_empty),
      .wr_head(wr_head), .rd_head(rd_head), .rr_head(rr_head),
      .override(ctrlmode_override), .override_value(ctrlmode_value), .ready(arb_ready),
      .wr_pop(wr_pop), .rd_pop(rd_pop), .rr_pop(rr_pop),
      .valid(arb_valid), .packet(arb_packet), .response(arb_response));

   etx_remap u_remap (
      .mi_clk(mi_clk), .rst_n(rst_n), .in_valid(arb_valid), .in_packet(arb_packet),
      .response(arb_response), .remap_enable(remap_enable),
      .mask(remap_mask), .pattern(remap_pattern), .out_ready(map_ready),
      .in_ready(arb_ready), .out_valid(map_valid), .out_packet(map_packet));

   etx_protocol u_protocol (
      .mi_clk(mi_clk), .rst_n(rst_n), .in_valid(map_valid), .in_packet(map_packet),
      .tx_enable(tx_enable), .txi_wr_wait(txi_wr_wait), .txi_rd_wait(txi_rd_wait),
      .in_ready(map_ready), .busy(busy), .txo_frame(txo_frame), .txo_data(txo_data));

endmodule

// ==== verification/etx_tb.sv ====
module etx_tb;

   localparam etx_pkg::chip_id_t CHIP_ID = 12'h0a5;
   localparam int QUEUE_DEPTH = 8;
   localparam int N_PRE   = 3;                 // Packets per channel in each phase
   localparam int N_BASIC = 20;
   localparam int N_SELF  = 12;
   localparam int N_REMAP = 16;
   localparam int N_WAIT  = 16;
   localparam int N_FILL  = 10;
   localparam int TOTAL_PACKETS = 3 * (N_PRE + N_BASIC + N_SELF + N_REMAP + N_WAIT + N_FILL);
   localparam int TIMEOUT_CYCLES = 200 * TOTAL_PACKETS + 1000;

   logic              mi_clk = 1'b0;
   logic              rst_n;
   logic              mi_en;
   logic              mi_we;
   etx_pkg::mi_addr_t mi_addr;
   etx_pkg::mi_data_t mi_din;
   etx_pkg::mi_data_t mi_dout;
   logic              wr_access;
   logic              rd_access;
   logic              rr_access;
   etx_pkg::packet_t  wr_packet;
   etx_pkg::packet_t  rd_packet;
   etx_pkg::packet_t  rr_packet;
   logic              wr_wait;
   logic              rd_wait;
   logic              rr_wait;
   logic              txo_frame;
   logic [7:0]        txo_data;
   logic              txi_wr_wait;
   logic              txi_rd_wait;

   etx_pkg::packet_t  src_q [3][$];            // Pending stimulus, 0 wr, 1 rd, 2 rr
   logic [31:0]       lfsr = 32'h5a;
   logic              toggle_on;
   logic              fill_done;
   logic              check_error;
   int                pending;                 // Packets still expected on the link

   always #5 mi_clk = ~mi_clk;

   etx_top #(.chip_id(CHIP_ID), .queue_depth(QUEUE_DEPTH)) dut (
      .mi_clk(mi_clk), .rst_n(rst_n), .mi_en(mi_en), .mi_we(mi_we), .mi_addr(mi_addr),
      .mi_din(mi_din), .mi_dout(mi_dout),
      .wr_access(wr_access), .wr_packet(wr_packet), .wr_wait(wr_wait),
      .rd_access(rd_access), .rd_packet(rd_packet), .rd_wait(rd_wait),
      .rr_access(rr_access), .rr_packet(rr_packet), .rr_wait(rr_wait),
      .txo_frame(txo_frame), .txo_data(txo_data),
      .txi_wr_wait(txi_wr_wait), .txi_rd_wait(txi_rd_wait));

   // Checker sits on the DUT ports
   etx_tb_checks #(.chip_id(CHIP_ID)) u_checks (
      .mi_clk(mi_clk), .rst_n(rst_n), .mi_en(mi_en), .mi_we(mi_we), .mi_addr(mi_addr),
      .mi_din(mi_din),
      .wr_access(wr_access), .wr_packet(wr_packet), .wr_wait(wr_wait),
      .rd_access(rd_access), .rd_packet(rd_packet), .rd_wait(rd_wait),
      .rr_access(rr_access), .rr_packet(rr_packet), .rr_wait(rr_wait),
      .txo_frame(txo_frame), .txo_data(txo_data),
      .txi_wr_wait(txi_wr_wait), .txi_rd_wait(txi_rd_wait),
      .error_seen(check_error), .pending(pending));

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] galois_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic random_bits(input int n, output logic [31:0] w);
      int i;
      w = '0;
      for (i = 0; i < n; i++)
      begin
         lfsr = galois_step(lfsr);             // One step per bit
         w    = {w[30:0], lfsr[0]};
      end
   endtask

   task automatic make_packet(input int ch, input bit to_self, output etx_pkg::packet_t p);
      logic [31:0] ctrl;
      logic [31:0] dm;
      logic [31:0] addr;
      logic [31:0] data;
      logic        write;
      random_bits(4, ctrl);
      random_bits(2, dm);
      random_bits(32, addr);
      random_bits(32, data);
      if (to_self)
         addr[31:20] = CHIP_ID;                // Aimed back at this chip
      write = (ch != 1);                       // Only read requests are non-writes
      p = {write, ctrl[3:0], dm[1:0], 1'b0, addr, data};
   endtask

   task automatic load_sources(input int n, input bit with_self);
      etx_pkg::packet_t p;
      int               ch;
      int               i;
      for (ch = 0; ch < 3; ch++)
      begin
         for (i = 0; i < n; i++)
         begin
            make_packet(ch, with_self && (i % 3 == 0), p);
            src_q[ch].push_back(p);
         end
      end
   endtask

   function automatic logic source_wait(int ch);
      case (ch)
         0:       return wr_wait;
         1:       return rd_wait;
         default: return rr_wait;
      endcase
   endfunction

   task automatic put_access(input int ch, input logic a, input etx_pkg::packet_t p);
      case (ch)
         0:
         begin
            wr_access <= a;
            wr_packet <= p;
         end
         1:
         begin
            rd_access <= a;
            rd_packet <= p;
         end
         default:
         begin
            rr_access <= a;
            rr_packet <= p;
         end
      endcase
   endtask

   task automatic drive_channel(input int ch);
      etx_pkg::packet_t p;
      while (src_q[ch].size() != 0)
      begin
         @(posedge mi_clk);
         if (source_wait(ch))
            put_access(ch, 1'b0, '0);          // Queue nearly full
         else
         begin
            p = src_q[ch].pop_front();
            put_access(ch, 1'b1, p);
         end
      end
      @(posedge mi_clk);
      put_access(ch, 1'b0, '0);
   endtask

   task automatic run_traffic();
      fork
         drive_channel(0);
         drive_channel(1);
         drive_channel(2);
      join
   endtask

   task automatic wait_drained();
      repeat (4) @(posedge mi_clk);
      while (pending != 0)
         @(negedge mi_clk);
      repeat (4) @(posedge mi_clk);           // Let the last gap pass
   endtask

   task automatic toggle_far_waits();
      int cyc;
      cyc = 0;
      while (toggle_on)
      begin
         @(posedge mi_clk);
         cyc = cyc + 1;
         txi_wr_wait <= (cyc % 7) < 3;         // Uneven periods so both mix
         txi_rd_wait <= (cyc % 11) < 5;
      end
      txi_wr_wait <= 1'b0;
      txi_rd_wait <= 1'b0;
   endtask

   task automatic write_reg(input etx_pkg::mi_addr_t a, input etx_pkg::mi_data_t d);
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b1;
      mi_addr <= a;
      mi_din  <= d;
      @(posedge mi_clk);
      mi_en   <= 1'b0;
      mi_we   <= 1'b0;
   endtask

   task automatic check_reg(input etx_pkg::mi_addr_t a, input etx_pkg::mi_data_t exp,
                            input string name);
      etx_pkg::mi_data_t v;
      @(posedge mi_clk);
      mi_en   <= 1'b1;
      mi_we   <= 1'b0;
      mi_addr <= a;
      @(posedge mi_clk);
      mi_en   <= 1'b0;
      @(posedge mi_clk);
      v = mi_dout;                             // Registered one cycle after the read
      assert (v == exp)
         else fail_run($sformatf("MISMATCH at time %0t: %s read %h, expected %h",
                                 $time, name, v, exp));
   endtask

   initial
   begin
      repeat (TIMEOUT_CYCLES) @(posedge mi_clk);
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   always @(posedge check_error)
      fail_run("Link checker reported an error");

   initial
   begin
      rst_n       <= 1'b0;
      mi_en       <= 1'b0;
      mi_we       <= 1'b0;
      mi_addr     <= '0;
      mi_din      <= '0;
      wr_access   <= 1'b0;
      rd_access   <= 1'b0;
      rr_access   <= 1'b0;
      wr_packet   <= '0;
      rd_packet   <= '0;
      rr_packet   <= '0;
      txi_wr_wait <= 1'b0;
      txi_rd_wait <= 1'b0;
      toggle_on   = 1'b0;
      fill_done   = 1'b0;
      repeat (16) @(posedge mi_clk);
      rst_n <= 1'b1;
      @(posedge mi_clk);
      check_reg(etx_pkg::REG_TX_CFG, 32'h0, "REG_TX_CFG after reset");
      // Packets sit in the queues while disabled
      load_sources(N_PRE, 1'b0);
      run_traffic();
      repeat (40) @(posedge mi_clk);
      write_reg(etx_pkg::REG_TX_CFG, 32'h1);
      load_sources(N_BASIC, 1'b0);
      run_traffic();
      wait_drained();
      load_sources(N_SELF, 1'b1);              // Every third packet to our own ID
      run_traffic();
      wait_drained();
      write_reg(etx_pkg::REG_REMAP_MASK, 32'h0f0f);
      write_reg(etx_pkg::REG_REMAP_PATTERN, 32'h03c5);
      write_reg(etx_pkg::REG_TX_CFG, 32'ha7);  // Enable, remap, override to 4'ha
      check_reg(etx_pkg::REG_TX_CFG, 32'ha7, "REG_TX_CFG");
      check_reg(etx_pkg::REG_REMAP_MASK, 32'h0f0f, "REG_REMAP_MASK");
      check_reg(etx_pkg::REG_REMAP_PATTERN, 32'h03c5, "REG_REMAP_PATTERN");
      load_sources(N_REMAP, 1'b0);
      run_traffic();
      wait_drained();
      // Far-end waits toggle under traffic
      load_sources(N_WAIT, 1'b0);
      toggle_on = 1'b1;
      fork
         begin
            run_traffic();
            wait_drained();
            toggle_on = 1'b0;
         end
         toggle_far_waits();
      join
      wait_drained();
      // Both far ends stalled, queues back up
      @(posedge mi_clk);
      txi_wr_wait <= 1'b1;
      txi_rd_wait <= 1'b1;
      load_sources(N_FILL, 1'b0);
      fork
         begin
            run_traffic();
            fill_done = 1'b1;
         end
      join_none
      @(negedge mi_clk);
      while (!(wr_wait && rd_wait && rr_wait))
         @(negedge mi_clk);
      check_reg(etx_pkg::REG_TX_STATUS, 32'h7, "REG_TX_STATUS while stalled");
      @(posedge mi_clk);
      txi_wr_wait <= 1'b0;
      txi_rd_wait <= 1'b0;
      while (!fill_done)
         @(negedge mi_clk);
      wait_drained();
      if (check_error)
         fail_run("Errors were reported during the run");
      else
      begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// ==== verification/etx_tb_checks.sv ====
module etx_tb_checks #(
   parameter etx_pkg::chip_id_t chip_id = '0
) (
   input  logic              mi_clk,
   input  logic              rst_n,
   input  logic              mi_en,
   input  logic              mi_we,
   input  etx_pkg::mi_addr_t mi_addr,
   input  etx_pkg::mi_data_t mi_din,
   input  logic              wr_access,
   input  etx_pkg::packet_t  wr_packet,
   input  logic              wr_wait,
   input  logic              rd_access,
   input  etx_pkg::packet_t  rd_packet,
   input  logic              rd_wait,
   input  logic              rr_access,
   input  etx_pkg::packet_t  rr_packet,
   input  logic              rr_wait,
   input  logic              txo_frame,
   input  logic [7:0]        txo_data,
   input  logic              txi_wr_wait,
   input  logic              txi_rd_wait,
   output logic              error_seen,
   output int                pending
);

   etx_pkg::packet_t wr_exp [$];               // Expected link packets per channel
   etx_pkg::packet_t rd_exp [$];
   etx_pkg::packet_t rr_exp [$];
   etx_pkg::packet_t frame;                    // Bytes collected from the lane
   int               nbytes;
   logic             hit;
   logic             cfg_enable;               // Shadow of the config registers
   logic             cfg_remap;
   logic             cfg_override;
   logic [3:0]       cfg_ctrl;
   logic [11:0]      cfg_mask;
   logic [11:0]      cfg_pattern;

   initial
   begin
      error_seen = 1'b0;
      pending    = 0;
   end

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      error_seen = 1'b1;
   endtask

   task automatic report_failure(input string msg);
      $display("Link check failed at time %0t: %s", $time, msg);
      error_seen = 1'b1;
   endtask

   // Layout: write 71, ctrlmode 70:67, datamode 66:65, rsvd 64, addr 63:32, data 31:0
   function automatic logic addressed_here(etx_pkg::packet_t p);
      return p[63:52] == chip_id;
   endfunction

   function automatic etx_pkg::packet_t expected_form(etx_pkg::packet_t p, logic resp);
      etx_pkg::packet_t e;
      int               b;
      e = p;
      if (!resp && cfg_override)
         e[70:67] = cfg_ctrl;                  // Forced control mode
      if (!resp && cfg_remap)
      begin
         for (b = 0; b < 12; b++)
            if (cfg_mask[b])
               e[52 + b] = cfg_pattern[b];     // Bit by bit, addr[20+b]
      end
      return e;
   endfunction

   always @(posedge mi_clk)
   begin
      if (!rst_n)
      begin
         wr_exp.delete();
         rd_exp.delete();
         rr_exp.delete();
         nbytes       = 0;
         frame        = '0;
         cfg_enable   = 1'b0;
         cfg_remap    = 1'b0;
         cfg_override = 1'b0;
         cfg_ctrl     = '0;
         cfg_mask     = '0;
         cfg_pattern  = '0;
      end
      else
      begin
         if (wr_access && !addressed_here(wr_packet))
            wr_exp.push_back(expected_form(wr_packet, 1'b0));
         if (rd_access && !addressed_here(rd_packet))
            rd_exp.push_back(expected_form(rd_packet, 1'b0));
         if (rr_access)
            rr_exp.push_back(expected_form(rr_packet, 1'b1)); // Never dropped
         if (mi_en && mi_we)
         begin
            case (mi_addr)
               etx_pkg::REG_TX_CFG:
               begin
                  cfg_enable   = mi_din[0];
                  cfg_remap    = mi_din[1];
                  cfg_override = mi_din[2];
                  cfg_ctrl     = mi_din[7:4];
               end
               etx_pkg::REG_REMAP_MASK:    cfg_mask    = mi_din[11:0];
               etx_pkg::REG_REMAP_PATTERN: cfg_pattern = mi_din[11:0];
               default:                    ;
            endcase
         end
         if (txo_frame)
         begin
            frame  = {frame[63:0], txo_data};  // MSB byte arrives first
            nbytes = nbytes + 1;
            if (nbytes == etx_pkg::PACKET_BYTES)
            begin
               nbytes = 0;
               hit    = 1'b1;
               if (rr_exp.size() != 0 && frame == rr_exp[0])
                  void'(rr_exp.pop_front());
               else if (wr_exp.size() != 0 && frame == wr_exp[0])
                  void'(wr_exp.pop_front());
               else if (rd_exp.size() != 0 && frame == rd_exp[0])
                  void'(rd_exp.pop_front());
               else
                  hit = 1'b0;
               a_frame_expected: assert (hit)
                  else report_mismatch($sformatf("frame %h is no channel's next packet", frame));
            end
         end
      end
      pending = wr_exp.size() + rd_exp.size() + rr_exp.size();
   end

   a_reset_idle: assert property (@(posedge mi_clk)
      $rose(rst_n) |-> !txo_frame && !wr_wait && !rd_wait && !rr_wait)
      else report_failure("link or a source wait active right after reset");
   a_frame_len: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $rose(txo_frame) |-> txo_frame [*9] ##1 !txo_frame)
      else report_failure("frame was not 9 bytes followed by a gap");
   a_enabled: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $rose(txo_frame) |-> $past(cfg_enable))
      else report_failure("frame started while the transmitter was disabled");
   // First byte MSB is the write flag
   a_wr_hold: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $rose(txo_frame) && txo_data[7] |-> !$past(txi_wr_wait))
      else report_failure("write frame started while txi_wr_wait was high");
   a_rd_hold: assert property (@(posedge mi_clk) disable iff (!rst_n)
      $rose(txo_frame) && !txo_data[7] |-> !$past(txi_rd_wait))
      else report_failure("read frame started while txi_rd_wait was high");

endmodule
